/* commitPkg.sv */
`default_nettype none

package commitPkg;

	////////////////////////////////////////
	// Lane and issue sizing
	////////////////////////////////////////

	localparam int numLanes = 4;			// Execution lanes in the array
	localparam int issueNoWidth = 6;		// Issue numbers wrap modulo 64

	// One bit per lane, used for enables and commit marks
	typedef logic [numLanes-1:0] laneMaskT;

	typedef logic [issueNoWidth-1:0] issueNoT;

	////////////////////////////////////////
	// Lane report and buffer entry
	////////////////////////////////////////

	// Completion report from one lane, valid for a single cycle
	typedef struct packed {
		logic valid;
		issueNoT issueNo;
	} laneReportT;

	// One outstanding issue in the commit aggregator
	typedef struct packed {
		logic valid;			// Entry holds a live issue
		laneMaskT enable;		// Lanes that execute this issue
		laneMaskT marks;		// Lanes that have reported back
		issueNoT issueNo;		// Number given by the dispatcher
	} commitEntryT;

endpackage

`default_nettype wire

/* ringBufferControl.sv */
`default_nettype none

module ringBufferControl #(
	parameter int depth = 4		// Entry count, a power of two
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic write,						// Allocate the entry at writeAddr
	input wire logic read,						// Release the entry at readAddr
	output logic [$clog2(depth)-1:0] writeAddr,
	output logic [$clog2(depth)-1:0] readAddr,
	output logic full,
	output logic empty
);

	localparam int countWidth = $clog2(depth + 1);

	logic [countWidth-1:0] count;	// Entries currently held

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr <= '0;
			count <= '0;
		end else begin
			if (write) writeAddr <= writeAddr + 1'b1;	// Wraps with the ring
			if (read) readAddr <= readAddr + 1'b1;

			// Simultaneous write and read leave the count unchanged
			case ({write, read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full = (count == countWidth'(depth));
	assign empty = (count == '0);

	// Callers must respect the flags
	noOverUnderflow: assert property (
		@(posedge clock) disable iff (reset)
		!(write && full) && !(read && empty)
	) else $error("ring buffer written while full or read while empty");

endmodule

`default_nettype wire

/* issueDispatcher.sv */
`default_nettype none

module issueDispatcher (
	input wire logic clock,
	input wire logic reset,
	input wire logic issueStrobe,					// Issue request from the scalar front end
	input wire commitPkg::laneMaskT issueLanes,		// Lanes enabled for this issue
	input wire logic full,							// Aggregator has no free entry
	output logic accept,							// One-cycle accept pulse
	output commitPkg::issueNoT acceptNo,			// Number of the accepted issue
	output commitPkg::laneMaskT acceptLanes			// Lane mask of the accepted issue
);

	commitPkg::issueNoT nextNo;	// Number handed to the next accepted issue

	////////////////////////////////////////
	// Acceptance
	////////////////////////////////////////

	// Strobe is taken in its own cycle unless the buffer is full
	assign accept = issueStrobe & ~full;
	assign acceptNo = nextNo;
	assign acceptLanes = issueLanes;

	////////////////////////////////////////
	// Issue numbering
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			nextNo <= '0;
		end else if (accept) begin
			nextNo <= nextNo + 1'b1;	// Wraps modulo 64
		end
	end

	// An issue is only accepted when the aggregator can hold it
	acceptNotFull: assert property (
		@(posedge clock) disable iff (reset)
		full |-> !accept
	) else $error("issue accepted while the commit buffer is full");

endmodule

`default_nettype wire

/* laneArray.sv */
`default_nettype none

module laneArray #(
	parameter int laneLatency = 3		// Delay of lane 0, lane j adds j cycles
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic accept,
	input wire commitPkg::issueNoT acceptNo,
	input wire commitPkg::laneMaskT acceptLanes,
	output commitPkg::laneReportT reports [commitPkg::numLanes]
);

	////////////////////////////////////////
	// Per-lane delay pipelines
	////////////////////////////////////////

	// Each lane stands in for execution with a fixed delay. The pipeline
	// shifts every cycle so several issues can be in flight at once
	for (genvar j = 0; j < commitPkg::numLanes; j++) begin : gLane
		localparam int depth = laneLatency + j;

		commitPkg::laneReportT stage [depth];

		always_ff @(posedge clock) begin
			if (reset) begin
				for (int k = 0; k < depth; k++) begin
					stage[k].valid <= 1'b0;	// Drop anything in flight
				end
			end else begin
				// Issue enters only lanes that are enabled for it
				stage[0] <= '{valid: accept & acceptLanes[j], issueNo: acceptNo};
				for (int k = 1; k < depth; k++) begin
					stage[k] <= stage[k-1];
				end
			end
		end

		// Report leaves after laneLatency + j cycles
		assign reports[j] = stage[depth-1];
	end

endmodule

`default_nettype wire

/* commitAggregator.sv */
`default_nettype none

module commitAggregator #(
	parameter int bufferDepth = 4		// Outstanding issues held, a power of two
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic accept,								// New issue from the dispatcher
	input wire commitPkg::issueNoT acceptNo,
	input wire commitPkg::laneMaskT acceptLanes,
	input wire commitPkg::laneReportT reports [commitPkg::numLanes],
	output logic commitReq,									// Head entry is complete
	output commitPkg::issueNoT commitNo,					// Number of the head entry
	input wire logic commitGrant,							// Scalar side takes the head
	output logic full
);

	localparam int addrWidth = $clog2(bufferDepth);

	commitPkg::commitEntryT entries [bufferDepth];
	commitPkg::laneMaskT markSet [bufferDepth];	// Marks to set this cycle, per entry
	commitPkg::laneMaskT reportValid;			// Valid bits of the lane reports
	commitPkg::laneMaskT reportHit;				// Report found an enabled entry

	logic [addrWidth-1:0] writeAddr;
	logic [addrWidth-1:0] readAddr;
	logic headRelease;

	////////////////////////////////////////
	// Report matching
	////////////////////////////////////////

	// A report marks its lane in every live entry with the same number
	always_comb begin
		reportHit = '0;
		for (int j = 0; j < commitPkg::numLanes; j++) begin
			reportValid[j] = reports[j].valid;
		end
		for (int i = 0; i < bufferDepth; i++) begin
			for (int j = 0; j < commitPkg::numLanes; j++) begin
				markSet[i][j] = entries[i].valid && entries[i].enable[j] &&
					reports[j].valid && (reports[j].issueNo == entries[i].issueNo);
				reportHit[j] = reportHit[j] | markSet[i][j];
			end
		end
	end

	////////////////////////////////////////
	// Head commit request
	////////////////////////////////////////

	// Empty-mask entries are complete as soon as they exist
	assign commitReq = entries[readAddr].valid &&
		(entries[readAddr].marks == entries[readAddr].enable);
	assign commitNo = entries[readAddr].issueNo;
	assign headRelease = commitReq & commitGrant;

	////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bufferDepth; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < bufferDepth; i++) begin
				entries[i].marks <= entries[i].marks | markSet[i];
			end
			if (headRelease) entries[readAddr].valid <= 1'b0;

			// Write slot never aliases the head while it is being released
			if (accept) begin
				entries[writeAddr] <= '{
					valid: 1'b1,
					enable: acceptLanes,
					marks: '0,
					issueNo: acceptNo
				};
			end
		end
	end

	ringBufferControl #(
		.depth(bufferDepth)
	) i_ringBufferControl (
		.clock(clock),
		.reset(reset),
		.write(accept),
		.read(headRelease),
		.writeAddr(writeAddr),
		.readAddr(readAddr),
		.full(full),
		.empty()
	);

	// Lanes only report for issues that enabled them and are still held
	reportMatchesEntry: assert property (
		@(posedge clock) disable iff (reset)
		(reportValid & ~reportHit) == '0
	) else $error("lane report with no enabled matching entry");

endmodule

`default_nettype wire

/* commitRetirer.sv */
`default_nettype none

module commitRetirer (
	input wire logic clock,
	input wire logic reset,
	input wire logic commitReq,					// Aggregated request from the buffer
	input wire commitPkg::issueNoT commitNo,
	input wire logic retireHold,				// Stalls retirement while high
	output logic commitGrant,
	output logic retireValid,					// One pulse per retired issue
	output commitPkg::issueNoT retireNo,
	output logic [15:0] retiredCount
);

	logic seenRetire;				// At least one issue retired since reset
	commitPkg::issueNoT lastNo;		// Number of the previous retirement

	////////////////////////////////////////
	// Grant and retire pulse
	////////////////////////////////////////

	assign commitGrant = commitReq & ~retireHold;
	assign retireValid = commitGrant;		// Same cycle as the release
	assign retireNo = commitNo;

	always_ff @(posedge clock) begin
		if (reset) begin
			retiredCount <= '0;
			seenRetire <= 1'b0;
		end else if (commitGrant) begin
			retiredCount <= retiredCount + 1'b1;
			seenRetire <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (commitGrant) lastNo <= commitNo;
	end

	// Retirement follows issue order, wrapping modulo 64
	retireInOrder: assert property (
		@(posedge clock) disable iff (reset)
		(retireValid && seenRetire) |->
			(retireNo == commitPkg::issueNoT'(lastNo + 1'b1))
	) else $error("retired issue %0d out of order", retireNo);

endmodule

`default_nettype wire

/* commitTop.sv */
`default_nettype none

module commitTop #(
	parameter int bufferDepth = 4,		// Commit buffer entries
	parameter int laneLatency = 3		// Base lane delay
) (
	input wire logic clock,
	input wire logic reset,

	// Issue side
	input wire logic issueStrobe,
	input wire commitPkg::laneMaskT issueLanes,
	output logic issueFull,
	output logic issueAccept,
	output commitPkg::issueNoT acceptedNo,

	// Retire side
	input wire logic retireHold,
	output logic retireValid,
	output commitPkg::issueNoT retireNo,
	output logic [15:0] retiredCount
);

	commitPkg::laneMaskT acceptLanes;
	commitPkg::laneReportT laneReports [commitPkg::numLanes];
	logic commitReq;
	commitPkg::issueNoT commitNo;
	logic commitGrant;

	////////////////////////////////////////
	// Issue and execution
	////////////////////////////////////////

	issueDispatcher i_issueDispatcher (
		.clock(clock),
		.reset(reset),
		.issueStrobe(issueStrobe),
		.issueLanes(issueLanes),
		.full(issueFull),
		.accept(issueAccept),
		.acceptNo(acceptedNo),
		.acceptLanes(acceptLanes)
	);

	laneArray #(
		.laneLatency(laneLatency)
	) i_laneArray (
		.clock(clock),
		.reset(reset),
		.accept(issueAccept),
		.acceptNo(acceptedNo),
		.acceptLanes(acceptLanes),
		.reports(laneReports)
	);

	////////////////////////////////////////
	// Commit and retirement
	////////////////////////////////////////

	commitAggregator #(
		.bufferDepth(bufferDepth)
	) i_commitAggregator (
		.clock(clock),
		.reset(reset),
		.accept(issueAccept),
		.acceptNo(acceptedNo),
		.acceptLanes(acceptLanes),
		.reports(laneReports),
		.commitReq(commitReq),
		.commitNo(commitNo),
		.commitGrant(commitGrant),
		.full(issueFull)
	);

	commitRetirer i_commitRetirer (
		.clock(clock),
		.reset(reset),
		.commitReq(commitReq),
		.commitNo(commitNo),
		.retireHold(retireHold),
		.commitGrant(commitGrant),
		.retireValid(retireValid),
		.retireNo(retireNo),
		.retiredCount(retiredCount)
	);

endmodule

`default_nettype wire

/* tbClock.sv */
`default_nettype none

module tbClock #(
	parameter int period = 20		// Clock period in time units
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

endmodule

`default_nettype wire

/* commitTb.sv */
`default_nettype none

module commitTb;

	localparam int bufferDepth = 4;
	localparam int laneLatency = 3;
	localparam int cycleLimit = 2000;		// All tests plus margin

	logic clock;
	logic reset;
	logic issueStrobe;
	commitPkg::laneMaskT issueLanes;
	logic retireHold;
	logic issueFull;
	logic issueAccept;
	commitPkg::issueNoT acceptedNo;
	logic retireValid;
	commitPkg::issueNoT retireNo;
	logic [15:0] retiredCount;

	commitPkg::issueNoT modelQueue [$];		// Accepted issues not yet retired
	commitPkg::issueNoT expectNo = '0;		// Number the next accepted issue must carry
	commitPkg::issueNoT lastAcceptNo;
	commitPkg::issueNoT lastRetireNo;
	int cycle = 0;
	int lastAcceptCycle;
	int lastRetireCycle;
	int acceptedTotal;
	int retiredTotal;
	int errorCount;
	int testStartErrors;
	int testsRun;
	int testsFailed;
	bit sawWrap;							// Retired 63 followed by 0
	string currentTest;
	logic [31:0] lfsrState;

	tbClock #(.period(20)) i_tbClock (.clock(clock));

	commitTop #(
		.bufferDepth(bufferDepth),
		.laneLatency(laneLatency)
	) i_commitTop (
		.clock(clock),
		.reset(reset),
		.issueStrobe(issueStrobe),
		.issueLanes(issueLanes),
		.issueFull(issueFull),
		.issueAccept(issueAccept),
		.acceptedNo(acceptedNo),
		.retireHold(retireHold),
		.retireValid(retireValid),
		.retireNo(retireNo),
		.retiredCount(retiredCount)
	);

	////////////////////////////////////////
	// Checks and stimulus helpers
	////////////////////////////////////////

	task automatic compareIssueNo(input string name, input commitPkg::issueNoT expected,
			input commitPkg::issueNoT actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareCount(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportProblem(input string what);
		$display("%s: %s", currentTest, what);
		errorCount++;
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) return (state >> 1) ^ 32'h80200003;	// Galois taps
		return state >> 1;
	endfunction

	task automatic drawMask(output commitPkg::laneMaskT mask);
		for (int j = 0; j < commitPkg::numLanes; j++) begin
			mask[j] = lfsrState[0];			// One step per bit taken
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// Strobe every cycle, retrying dropped strobes, until count are accepted
	task automatic issueMany(input int count, input bit useRandom,
			input commitPkg::laneMaskT fixedMask);
		int taken;
		commitPkg::laneMaskT mask;
		taken = 0;
		mask = fixedMask;
		if (useRandom) drawMask(mask);
		while (taken < count) begin
			@(posedge clock);
			issueStrobe <= 1'b1;
			issueLanes <= mask;
			@(negedge clock);
			if (issueAccept) begin
				taken++;
				if (useRandom) drawMask(mask);
			end
		end
		@(posedge clock);
		issueStrobe <= 1'b0;
	endtask

	task automatic waitRetired(input int target);
		while (retiredTotal < target) @(negedge clock);
	endtask

	task automatic checkDrained;
		@(posedge clock);
		@(negedge clock);				// retiredCount settles after the last pulse
		if (modelQueue.size() != 0) reportProblem("accepted issues were never retired");
		compareCount({currentTest, " retiredCount"}, 16'(retiredTotal), retiredCount);
	endtask

	task automatic startTest(input string name);
		currentTest = name;
		testStartErrors = errorCount;
	endtask

	task automatic finishTest;
		testsRun++;
		if (errorCount == testStartErrors) begin
			$display("%s: ok", currentTest);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", currentTest, errorCount - testStartErrors);
		end
	endtask

	////////////////////////////////////////
	// Monitor and watchdog
	////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			if (issueAccept) begin
				compareIssueNo({currentTest, " accepted number"}, expectNo, acceptedNo);
				modelQueue.push_back(expectNo);
				lastAcceptNo = expectNo;
				expectNo = expectNo + 1'b1;		// Numbers wrap modulo 64
				lastAcceptCycle = cycle;
				acceptedTotal++;
			end
			if (retireValid) begin
				if (retireHold) reportProblem("retire pulse while retireHold is high");
				if (modelQueue.size() == 0) begin
					reportProblem("retire pulse with no issue outstanding");
				end else begin
					compareIssueNo({currentTest, " retire order"}, modelQueue.pop_front(),
						retireNo);
				end
				if (retiredTotal > 0 && lastRetireNo == 6'd63 && retireNo == 6'd0) sawWrap = 1'b1;
				lastRetireNo = retireNo;
				lastRetireCycle = cycle;
				retiredTotal++;
			end
		end
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			$display("Timeout after %0d cycles in %s", cycle, currentTest);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Idle design, one issue, latency from accept to retire pulse
	task automatic latencyTest(input string name, input commitPkg::laneMaskT mask,
			input int expected);
		startTest(name);
		issueMany(1, 1'b0, mask);
		waitRetired(acceptedTotal);
		compareCount({name, " latency"}, 16'(expected), 16'(lastRetireCycle - lastAcceptCycle));
		compareIssueNo({name, " number"}, lastAcceptNo, lastRetireNo);
		checkDrained();
		finishTest();
	endtask

	task automatic backPressureTest;
		int accepted;
		int tries;
		bit fullSeen;
		startTest("back-pressure");
		accepted = 0;
		tries = 0;
		fullSeen = 1'b0;
		@(posedge clock);
		retireHold <= 1'b1;
		while (!fullSeen && tries < 4 * bufferDepth) begin
			@(posedge clock);
			issueStrobe <= 1'b1;
			issueLanes <= 4'b1111;
			@(negedge clock);
			if (issueAccept) accepted++;
			if (issueFull) fullSeen = 1'b1;
			tries++;
		end
		if (!fullSeen) reportProblem("issueFull never rose under retireHold");
		compareCount({currentTest, " accepted under hold"}, 16'(bufferDepth), 16'(accepted));
		@(negedge clock);				// Strobe still high one more cycle
		if (issueAccept) reportProblem("strobe accepted while the buffer is full");
		@(posedge clock);
		issueStrobe <= 1'b0;
		retireHold <= 1'b0;
		waitRetired(acceptedTotal);
		checkDrained();
		finishTest();
	endtask

	initial begin
		reset = 1'b1;
		issueStrobe = 1'b0;
		issueLanes = '0;
		retireHold = 1'b0;
		lfsrState = 32'h97f1;
		errorCount = 0;
		currentTest = "reset";
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		// Outputs come out of reset idle
		@(negedge clock);
		if (issueFull) reportProblem("issueFull high after reset");
		if (issueAccept) reportProblem("issueAccept high after reset");
		if (retireValid) reportProblem("retireValid high after reset");
		compareCount({currentTest, " retiredCount"}, 16'd0, retiredCount);

		latencyTest("single issue, all lanes", 4'b1111, laneLatency + 3 + 1);
		latencyTest("lane 0 only", 4'b0001, laneLatency + 1);
		latencyTest("empty mask", 4'b0000, 1);

		startTest("back-to-back issues");
		issueMany(20, 1'b1, '0);
		waitRetired(acceptedTotal);
		checkDrained();
		finishTest();

		backPressureTest();

		startTest("wraparound");
		sawWrap = 1'b0;
		issueMany(70, 1'b1, '0);
		waitRetired(acceptedTotal);
		if (!sawWrap) reportProblem("issue numbers did not wrap past 63");
		checkDrained();
		finishTest();

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
commitPkg.sv
ringBufferControl.sv
issueDispatcher.sv
laneArray.sv
commitAggregator.sv
commitRetirer.sv
commitTop.sv
tbClock.sv
commitTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = commitTb
RTL_TOP   = commitTop
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
